// File: Bender.yml
package:
  name: hdmi_cfg

sources:
  - source/hdmi_cfg_pkg.sv
  - source/settings_sampler.sv
  - source/mode_decoder.sv
  - source/register_sequencer.sv
  - source/hdmi_cfg_top.sv
  - target: simulation
    files:
      - bench/hdmi_cfg_tb.sv

// File: bench/hdmi_cfg_tb.sv
`timescale 1ns/1ps

module hdmi_cfg_tb;

    typedef hdmi_cfg_pkg::reg_write_t [0:7] write_list_t;

    localparam int CHANGE_COUNT   = 31;
    localparam int FULL_SEQUENCES = CHANGE_COUNT - 2;  // two runs cut short by a restart
    localparam int TIMEOUT_CYCLES = CHANGE_COUNT * hdmi_cfg_pkg::WRITE_COUNT * 6 + 200;
    localparam hdmi_cfg_pkg::settings_t START_SETTINGS = '{mode: 7'h00, clock_delay: 3'd3,
                                                           colorspace: 2'd0};
    localparam logic [6:0] LISTED_MODES [20] = '{
        7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h10, 7'h11, 7'h12,
        7'h13, 7'h20, 7'h21, 7'h22, 7'h23, 7'h40, 7'h41, 7'h42, 7'h43, 7'h00
    };

    logic                        clock;
    logic                        rst_n;
    hdmi_cfg_pkg::settings_t     settings;
    hdmi_cfg_pkg::video_config_t video_config;
    logic                        reconf;
    logic                        credit_return = 1'b0;
    logic                        write_valid;
    hdmi_cfg_pkg::reg_write_t    write;
    logic                        busy;

    int     cycle = 0;
    integer seed  = 10;
    int     value_errors = 0;
    int     other_errors = 0;

    hdmi_cfg_pkg::video_config_t cfg_queue[$];  // configs waiting for their reconf
    int                          reconf_due[$];
    hdmi_cfg_pkg::reg_write_t    held[$];       // writes the sink still owes a credit for

    hdmi_cfg_pkg::video_config_t cur_cfg = hdmi_cfg_pkg::RESET_CONFIG;
    write_list_t                 exp_list;
    int                          exp_index = 0;
    logic                        seq_active = 1'b0;
    logic                        expect_reconf;
    int                          outstanding = 0;
    int                          writes_checked = 0;
    int                          sequences_done = 0;
    int                          wait_left = 0;

    hdmi_cfg_pkg::video_config_t model_cfg = hdmi_cfg_pkg::RESET_CONFIG;
    hdmi_cfg_pkg::settings_t     next_settings;
    logic [6:0]                  vic_before;

    hdmi_cfg_top hdmi_cfg_top_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .settings      (settings),
        .video_config  (video_config),
        .reconf        (reconf),
        .credit_return (credit_return),
        .write_valid   (write_valid),
        .write         (write),
        .busy          (busy)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // expected record after one settings change
    function automatic hdmi_cfg_pkg::video_config_t expected_config(
        input hdmi_cfg_pkg::settings_t s,
        input hdmi_cfg_pkg::video_config_t prev
    );
        hdmi_cfg_pkg::video_config_t cfg;
        cfg = prev;
        for (int i = 0; i < hdmi_cfg_pkg::MODE_COUNT; i++) begin
            if (hdmi_cfg_pkg::MODE_TABLE[i].code == s.mode) begin
                cfg.vic          = hdmi_cfg_pkg::MODE_TABLE[i].vic;
                cfg.pixel_repeat = hdmi_cfg_pkg::MODE_TABLE[i].pixel_repeat;
                cfg.interlaced   = hdmi_cfg_pkg::MODE_TABLE[i].interlaced;
                cfg.line_doubled = hdmi_cfg_pkg::MODE_TABLE[i].line_doubled;
            end
        end
        cfg.colorspace  = s.colorspace;
        cfg.clock_delay = s.clock_delay;
        return cfg;
    endfunction

    function automatic write_list_t expected_writes(input hdmi_cfg_pkg::video_config_t cfg);
        write_list_t list;
        list[0] = '{addr: 8'h15, data: 8'h00};
        list[1] = '{addr: 8'h16, data: {cfg.colorspace, 6'b0} | 8'h30};
        list[2] = '{addr: 8'h17, data: {6'b0, cfg.interlaced, 1'b0}};
        list[3] = '{addr: 8'h18, data: (cfg.colorspace == 2'd1) ? 8'h80 : 8'h00};
        list[4] = '{addr: 8'h3B, data: {5'b0, cfg.pixel_repeat, 1'b0}};
        list[5] = '{addr: 8'h3C, data: {1'b0, cfg.vic}};
        list[6] = '{addr: 8'hAF, data: 8'h06};
        list[7] = '{addr: 8'hBA, data: {cfg.clock_delay, 5'b0}};
        return list;
    endfunction

    // credit-returning I2C master stand-in
    always @(posedge clock) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
            held.delete();
            wait_left = 0;
        end else begin
            credit_return <= 1'b0;
            if (write_valid) begin
                held.push_back(write);
            end
            if (held.size() > 0) begin
                if (wait_left == 0) begin
                    credit_return <= 1'b1;
                    void'(held.pop_front());
                    wait_left = {$random(seed)} % 6;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    always @(posedge clock) begin
        if (rst_n) begin
            expect_reconf = (reconf_due.size() > 0) && (reconf_due[0] == cycle);
            if (reconf !== expect_reconf) begin
                $display("ERR %0t reconf expected %b got %b", $time, expect_reconf, reconf);
                value_errors++;
            end
            if (expect_reconf) begin
                void'(reconf_due.pop_front());
            end
            if (reconf) begin
                if (cfg_queue.size() == 0) begin
                    $display("reconf pulse at %0t with no settings change behind it", $time);
                    other_errors++;
                end else begin
                    cur_cfg = cfg_queue.pop_front();
                end
            end
            if (video_config !== cur_cfg) begin
                $display("ERR %0t video_config expected %h got %h", $time, cur_cfg, video_config);
                value_errors++;
            end
            if (busy !== seq_active) begin
                $display("ERR %0t busy expected %b got %b", $time, seq_active, busy);
                value_errors++;
            end
            if (write_valid) begin
                outstanding++;
                if (!seq_active) begin
                    $display("write at %0t while no sequence was running", $time);
                    other_errors++;
                end else begin
                    if (write.addr !== exp_list[exp_index].addr) begin
                        $display("ERR %0t write.addr expected %h got %h", $time,
                                 exp_list[exp_index].addr, write.addr);
                        value_errors++;
                    end
                    if (write.data !== exp_list[exp_index].data) begin
                        $display("ERR %0t write.data expected %h got %h", $time,
                                 exp_list[exp_index].data, write.data);
                        value_errors++;
                    end
                    writes_checked++;
                    exp_index++;
                    if (exp_index == hdmi_cfg_pkg::WRITE_COUNT) begin
                        seq_active = 1'b0;
                        sequences_done++;
                    end
                end
            end
            if (credit_return) begin
                outstanding--;
            end
            if (outstanding > hdmi_cfg_pkg::CREDIT_MAX) begin
                $display("%0d writes outstanding at %0t, more than the credit depth",
                         outstanding, $time);
                other_errors++;
            end
            if (reconf) begin  // restart once the old write above is done
                exp_list   = expected_writes(cur_cfg);
                exp_index  = 0;
                seq_active = 1'b1;
            end
        end
    end

    task automatic apply_settings(input hdmi_cfg_pkg::settings_t next);
        @(posedge clock);
        settings <= next;
        model_cfg = expected_config(next, model_cfg);
        cfg_queue.push_back(model_cfg);
        reconf_due.push_back(cycle + 3);  // sampler, decoder, then seen a cycle later
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clock);
        end while (busy || seq_active || cfg_queue.size() != 0 || reconf_due.size() != 0);
    endtask

    task automatic check_vic_kept(input logic [6:0] vic_old);
        if (video_config.vic !== vic_old) begin
            $display("ERR %0t video_config.vic expected %h got %h", $time, vic_old,
                     video_config.vic);
            value_errors++;
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d writes checked, %0d sequences, %0d value errors, %0d other errors",
                 writes_checked, sequences_done, value_errors, other_errors);
    endtask

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the write sequences did not finish", cycle);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        settings = START_SETTINGS;
        rst_n    = 1'b0;
        next_settings = START_SETTINGS;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        repeat (12) @(posedge clock);  // nothing may happen while idle

        for (int i = 0; i < 20; i++) begin
            next_settings.mode = LISTED_MODES[i];
            apply_settings(next_settings);
            wait_idle();
        end
        next_settings.mode = 7'h42;
        apply_settings(next_settings);
        wait_idle();
        next_settings.mode = 7'h05;  // unlisted codes
        apply_settings(next_settings);
        wait_idle();
        next_settings.mode = 7'h7F;
        apply_settings(next_settings);
        wait_idle();

        vic_before = model_cfg.vic;
        next_settings.clock_delay = 3'd6;
        apply_settings(next_settings);
        wait_idle();
        next_settings.clock_delay = 3'd0;
        apply_settings(next_settings);
        wait_idle();
        next_settings.colorspace = 2'd1;
        apply_settings(next_settings);
        wait_idle();
        next_settings.colorspace = 2'd2;
        apply_settings(next_settings);
        wait_idle();
        check_vic_kept(vic_before);

        // change during a running sequence
        apply_settings('{mode: 7'h12, clock_delay: 3'd5, colorspace: 2'd1});
        while (!(seq_active && exp_index >= 3)) @(negedge clock);
        apply_settings('{mode: 7'h20, clock_delay: 3'd2, colorspace: 2'd0});
        wait_idle();
        apply_settings('{mode: 7'h0A, clock_delay: 3'd2, colorspace: 2'd0});
        apply_settings('{mode: 7'h03, clock_delay: 3'd7, colorspace: 2'd3});
        wait_idle();

        while (outstanding != 0) @(negedge clock);
        repeat (5) @(posedge clock);
        if (sequences_done != FULL_SEQUENCES) begin
            $display("%0d complete write sequences seen where %0d were expected",
                     sequences_done, FULL_SEQUENCES);
            other_errors++;
        end
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/hdmi_cfg_pkg.sv
source/settings_sampler.sv
source/mode_decoder.sv
source/register_sequencer.sv
source/hdmi_cfg_top.sv
bench/hdmi_cfg_tb.sv

// File: source/hdmi_cfg_pkg.sv
package hdmi_cfg_pkg;

    // host mode codes, lower two bits select the variant in the banked groups
    localparam logic [6:0] MODE_1080P     = 7'h00;
    localparam logic [6:0] MODE_960P      = 7'h01;
    localparam logic [6:0] MODE_480P      = 7'h02;
    localparam logic [6:0] MODE_VGA       = 7'h03;
    localparam logic [6:0] MODE_576P_BASE = 7'h08;
    localparam logic [6:0] MODE_240P_BASE = 7'h10;
    localparam logic [6:0] MODE_480I_BASE = 7'h20;
    localparam logic [6:0] MODE_576I_BASE = 7'h40;

    // CEA-861 video identification codes
    localparam logic [6:0] VIC_960P  = 7'd0;  // no CEA code
    localparam logic [6:0] VIC_VGA   = 7'd1;
    localparam logic [6:0] VIC_480P  = 7'd2;
    localparam logic [6:0] VIC_480I  = 7'd6;
    localparam logic [6:0] VIC_1080P = 7'd16;
    localparam logic [6:0] VIC_576P  = 7'd17;
    localparam logic [6:0] VIC_576I  = 7'd21;

    typedef struct packed {
        logic [6:0] mode;
        logic [2:0] clock_delay;
        logic [1:0] colorspace;
    } settings_t;

    typedef struct packed {
        settings_t settings;
        logic      mode_changed;
        logic      delay_changed;
        logic      colorspace_changed;
    } change_t;

    typedef struct packed {
        logic [6:0] vic;
        logic [1:0] pixel_repeat;
        logic       interlaced;
        logic       line_doubled;
        logic [1:0] colorspace;
        logic [2:0] clock_delay;
    } video_config_t;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [6:0] code;
        logic [6:0] vic;
        logic [1:0] pixel_repeat;
        logic       interlaced;
        logic       line_doubled;
    } mode_entry_t;

    localparam int MODE_COUNT = 20;

    localparam mode_entry_t [0:MODE_COUNT-1] MODE_TABLE = '{
        '{code: MODE_1080P,       vic: VIC_1080P, pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: MODE_960P,        vic: VIC_960P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: MODE_480P,        vic: VIC_480P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: MODE_VGA,         vic: VIC_VGA,   pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: 7'h08,            vic: VIC_576P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: 7'h09,            vic: VIC_576P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: 7'h0A,            vic: VIC_576P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: 7'h0B,            vic: VIC_576P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b0},
        '{code: MODE_240P_BASE,   vic: VIC_1080P, pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b1},
        '{code: 7'h11,            vic: VIC_960P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b1},
        '{code: 7'h12,            vic: VIC_480P,  pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b1},
        '{code: 7'h13,            vic: VIC_VGA,   pixel_repeat: 2'd0, interlaced: 1'b0, line_doubled: 1'b1},
        '{code: MODE_480I_BASE,   vic: VIC_480I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h21,            vic: VIC_480I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h22,            vic: VIC_480I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h23,            vic: VIC_480I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: MODE_576I_BASE,   vic: VIC_576I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h41,            vic: VIC_576I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h42,            vic: VIC_576I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0},
        '{code: 7'h43,            vic: VIC_576I,  pixel_repeat: 2'd1, interlaced: 1'b1, line_doubled: 1'b0}
    };

    // delay code lands in bits 7:5, code 3 is the zero-skew point
    localparam logic [0:7][7:0] DELAY_BYTE = '{
        8'h00,  // -1.2 ns
        8'h20,  // -0.8 ns
        8'h40,  // -0.4 ns
        8'h60,  // nominal
        8'h80,  // +0.4 ns
        8'hA0,  // +0.8 ns
        8'hC0,  // +1.2 ns
        8'hE0   // +1.6 ns
    };

    localparam video_config_t RESET_CONFIG = '{
        vic:          VIC_1080P,
        pixel_repeat: 2'd0,
        interlaced:   1'b0,
        line_doubled: 1'b0,
        colorspace:   2'd0,
        clock_delay:  3'd3
    };

    // ADV7513 registers touched by a reconfiguration
    localparam logic [7:0] ADDR_INPUT_ID   = 8'h15;
    localparam logic [7:0] ADDR_OUT_FORMAT = 8'h16;
    localparam logic [7:0] ADDR_SYNC_CTRL  = 8'h17;
    localparam logic [7:0] ADDR_CSC_CTRL   = 8'h18;
    localparam logic [7:0] ADDR_PIX_REPEAT = 8'h3B;
    localparam logic [7:0] ADDR_VIC        = 8'h3C;
    localparam logic [7:0] ADDR_HDMI_MODE  = 8'hAF;
    localparam logic [7:0] ADDR_CLK_DELAY  = 8'hBA;

    localparam int WRITE_COUNT = 8;
    localparam int INDEX_WIDTH = $clog2(WRITE_COUNT);
    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(WRITE_COUNT - 1);

    localparam logic [0:WRITE_COUNT-1][7:0] REG_ADDR = '{
        ADDR_INPUT_ID, ADDR_OUT_FORMAT, ADDR_SYNC_CTRL, ADDR_CSC_CTRL,
        ADDR_PIX_REPEAT, ADDR_VIC, ADDR_HDMI_MODE, ADDR_CLK_DELAY
    };

    localparam logic [7:0] DATA_INPUT_ID  = 8'h00;  // 24-bit RGB, separate syncs
    localparam logic [7:0] DATA_HDMI_MODE = 8'h06;  // HDMI mode, HDCP off

    localparam int CREDIT_WIDTH = 3;
    localparam logic [CREDIT_WIDTH-1:0] CREDIT_MAX = 3'd4;

endpackage

// File: source/hdmi_cfg_top.sv
`timescale 1ns/1ps

module hdmi_cfg_top (
    input  logic                        clock,
    input  logic                        rst_n,
    input  hdmi_cfg_pkg::settings_t     settings,
    output hdmi_cfg_pkg::video_config_t video_config,
    output logic                        reconf,
    input  logic                        credit_return,
    output logic                        write_valid,
    output hdmi_cfg_pkg::reg_write_t    write,
    output logic                        busy
);

    logic                  change_valid;
    hdmi_cfg_pkg::change_t change;

    settings_sampler settings_sampler_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .settings     (settings),
        .change_valid (change_valid),
        .change       (change)
    );

    mode_decoder mode_decoder_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .change_valid (change_valid),
        .change       (change),
        .video_config (video_config),
        .reconf       (reconf)
    );

    register_sequencer register_sequencer_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .video_config  (video_config),
        .reconf        (reconf),
        .credit_return (credit_return),
        .write_valid   (write_valid),
        .write         (write),
        .busy          (busy)
    );

endmodule

// File: source/mode_decoder.sv
`timescale 1ns/1ps

module mode_decoder (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        change_valid,
    input  hdmi_cfg_pkg::change_t       change,
    output hdmi_cfg_pkg::video_config_t video_config,
    output logic                        reconf
);

    hdmi_cfg_pkg::mode_entry_t   mode_entry;
    logic                        mode_hit;
    hdmi_cfg_pkg::video_config_t next_config;

    // table search, at most one entry matches
    always_comb begin
        mode_entry = '0;
        mode_hit   = 1'b0;
        for (int i = 0; i < hdmi_cfg_pkg::MODE_COUNT; i++) begin
            if (hdmi_cfg_pkg::MODE_TABLE[i].code == change.settings.mode) begin
                mode_entry = hdmi_cfg_pkg::MODE_TABLE[i];
                mode_hit   = 1'b1;
            end
        end
    end

    always_comb begin
        next_config = video_config;
        // unlisted codes leave the timing fields alone
        if (change.mode_changed && mode_hit) begin
            next_config.vic          = mode_entry.vic;
            next_config.pixel_repeat = mode_entry.pixel_repeat;
            next_config.interlaced   = mode_entry.interlaced;
            next_config.line_doubled = mode_entry.line_doubled;
        end
        if (change.delay_changed) begin
            next_config.clock_delay = change.settings.clock_delay;
        end
        next_config.colorspace = change.settings.colorspace;  // always taken
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            video_config <= hdmi_cfg_pkg::RESET_CONFIG;
            reconf       <= 1'b0;
        end else begin
            reconf <= change_valid;  // single pulse per change
            if (change_valid) begin
                video_config <= next_config;
            end
        end
    end

endmodule

// File: source/register_sequencer.sv
`timescale 1ns/1ps

module register_sequencer (
    input  logic                        clock,
    input  logic                        rst_n,
    input  hdmi_cfg_pkg::video_config_t video_config,
    input  logic                        reconf,
    input  logic                        credit_return,
    output logic                        write_valid,
    output hdmi_cfg_pkg::reg_write_t    write,
    output logic                        busy
);

    hdmi_cfg_pkg::video_config_t             latched_config;
    logic [hdmi_cfg_pkg::INDEX_WIDTH-1:0]    index;
    logic [hdmi_cfg_pkg::CREDIT_WIDTH-1:0]   credits;
    logic [7:0]                              addr;
    logic [7:0]                              data;
    logic                                    issue;
    logic                                    last;

    assign issue       = busy && (credits != '0);  // stall when out of credits
    assign last        = (index == hdmi_cfg_pkg::LAST_INDEX);
    assign addr        = hdmi_cfg_pkg::REG_ADDR[index];
    assign write_valid = issue;
    assign write       = '{addr: addr, data: data};

    // register payload from the latched record
    always_comb begin
        case (addr)
            hdmi_cfg_pkg::ADDR_INPUT_ID: begin
                data = hdmi_cfg_pkg::DATA_INPUT_ID;
            end
            hdmi_cfg_pkg::ADDR_OUT_FORMAT: begin
                data = {latched_config.colorspace, 6'b11_0000};
            end
            hdmi_cfg_pkg::ADDR_SYNC_CTRL: begin
                data = {6'b0, latched_config.interlaced, 1'b0};
            end
            hdmi_cfg_pkg::ADDR_CSC_CTRL: begin
                data = (latched_config.colorspace == 2'd1) ? 8'h80 : 8'h00;  // CSC on for YCbCr
            end
            hdmi_cfg_pkg::ADDR_PIX_REPEAT: begin
                data = {5'b0, latched_config.pixel_repeat, 1'b0};
            end
            hdmi_cfg_pkg::ADDR_VIC: begin
                data = {1'b0, latched_config.vic};
            end
            hdmi_cfg_pkg::ADDR_HDMI_MODE: begin
                data = hdmi_cfg_pkg::DATA_HDMI_MODE;
            end
            hdmi_cfg_pkg::ADDR_CLK_DELAY: begin
                data = hdmi_cfg_pkg::DELAY_BYTE[latched_config.clock_delay];
            end
            default: begin
                data = 8'h00;
            end
        endcase
    end

    // one credit per write, one back per return pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            credits <= hdmi_cfg_pkg::CREDIT_MAX;
        end else begin
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // a reconf wins over sequence end, restarting from the top
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            index <= '0;
        end else if (reconf) begin
            busy  <= 1'b1;
            index <= '0;
        end else if (issue) begin
            if (last) begin
                busy  <= 1'b0;
                index <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reconf) begin
            latched_config <= video_config;
        end
    end

endmodule

// File: source/settings_sampler.sv
`timescale 1ns/1ps

module settings_sampler (
    input  logic                    clock,
    input  logic                    rst_n,
    input  hdmi_cfg_pkg::settings_t settings,
    output logic                    change_valid,
    output hdmi_cfg_pkg::change_t   change
);

    hdmi_cfg_pkg::settings_t prev_settings;
    logic                    mode_diff;
    logic                    delay_diff;
    logic                    colorspace_diff;
    logic                    any_diff;

    // per-field compare against last cycle's copy
    assign mode_diff       = (settings.mode != prev_settings.mode);
    assign delay_diff      = (settings.clock_delay != prev_settings.clock_delay);
    assign colorspace_diff = (settings.colorspace != prev_settings.colorspace);
    assign any_diff        = mode_diff | delay_diff | colorspace_diff;

    // tracked through reset too, so release sees no false change
    always_ff @(posedge clock) begin
        prev_settings <= settings;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            change_valid <= 1'b0;
        end else begin
            change_valid <= any_diff;
        end
    end

    always_ff @(posedge clock) begin
        change <= '{
            settings:           settings,
            mode_changed:       mode_diff,
            delay_changed:      delay_diff,
            colorspace_changed: colorspace_diff
        };
    end

endmodule
